/* vlog.f */
serial_slave_pkg.sv
control_frame_receiver.sv
write_word_receiver.sv
transfer_controller.sv
word_memory.sv
read_word_sender.sv
serial_slave.sv
serial_slave_assertions.sv
serial_slave_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= serial_slave_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Done: errors found
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* serial_slave_tb.sv */
// Table-driven testbench for serial_slave with a bit-level master and reference memory; sim top
`timescale 1ns/1ps

module serial_slave_tb;
    import serial_slave_pkg::*;

    localparam int READ_DELAY = 2;
    localparam int NUM_TXN    = 10;

    // one bus transaction with its kind, frame fields, word count and expected outcome
    typedef struct packed {
        logic      write;
        start_t    start;
        slave_id_t id;
        addr_t     addr;
        int        len;
        logic      accept;
    } txn_t;

    logic        clk = 1'b0;
    logic        rstN;
    logic        control;
    logic        wD;
    logic        valid;
    logic        last;
    logic        rD;
    logic        rvalid;
    logic        ready;
    txn_t        txns [NUM_TXN];
    data_t       ref_mem [256];
    int unsigned lcg_state = 93803;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    always #20 clk = ~clk;

    serial_slave #(
        .SLAVE_ID   (2'd1),
        .READ_DELAY (READ_DELAY),
        .MEM_DEPTH  (256)
    ) serial_slave_i (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .rvalid  (rvalid),
        .ready   (ready)
    );

    // watchdog on the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // rough upper bound of cycles for one table entry
    function automatic int txn_cycles(input txn_t t);
        int n;
        n = FRAME_BITS + 4;
        if (t.write) begin
            n += t.len * (2 * DATA_WIDTH + 1);
        end else begin
            n += READ_DELAY + 2 * DATA_WIDTH + t.len * (DATA_WIDTH + 2);
        end
        return n;
    endfunction

    task automatic fill_table();
        txns[0] = '{1'b1, START_PATTERN, 2'd1, 8'h10, 1, 1'b1};
        txns[1] = '{1'b0, START_PATTERN, 2'd1, 8'h10, 1, 1'b1};
        txns[2] = '{1'b1, START_PATTERN, 2'd1, 8'h20, 4, 1'b1};
        txns[3] = '{1'b0, START_PATTERN, 2'd1, 8'h20, 4, 1'b1};
        // rejected frames with wrong id and wrong start pattern aimed at 0x10
        txns[4] = '{1'b1, START_PATTERN, 2'd2, 8'h10, 1, 1'b0};
        txns[5] = '{1'b1, 3'b101, 2'd1, 8'h10, 1, 1'b0};
        txns[6] = '{1'b0, START_PATTERN, 2'd3, 8'h10, 1, 1'b0};
        txns[7] = '{1'b0, START_PATTERN, 2'd1, 8'h10, 1, 1'b1};
        // burst across the top of the address space
        txns[8] = '{1'b1, START_PATTERN, 2'd1, 8'hfe, 3, 1'b1};
        txns[9] = '{1'b0, START_PATTERN, 2'd1, 8'hfe, 3, 1'b1};
    endtask

    task automatic check_word(input addr_t addr, input data_t got, input data_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED rD word at addr %h: got %h, expected %h", addr, got, exp);
        end
    endtask

    task automatic check_ready(input logic exp);
        if (ready !== exp) begin
            value_errors++;
            $display("CHECK FAILED ready: got %h, expected %h", ready, exp);
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("CHECK FAILED rvalid %s: got %h cycles, expected %h", what, got, exp);
        end
    endtask

    task automatic expect_idle(input int n);
        repeat (n) begin
            check_ready(1'b1);
            if (rvalid !== 1'b0) begin
                other_errors++;
                $display("rvalid went high while no read transfer was accepted");
            end
            @(negedge clk);
        end
    endtask

    // returns in the cycle after the final frame bit
    task automatic send_frame(input txn_t t);
        logic [FRAME_BITS-1:0] bits;
        bits = {t.start, t.id, t.write, t.len > 1, t.addr};
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            @(negedge clk);
            control = bits[i];
        end
        @(negedge clk);
        control = 1'b0;
    endtask

    task automatic send_word(input data_t w, input logic is_last);
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            // roughly one bit in eight is preceded by a gap
            if ((lcg_next() >> 29) == 0) begin
                @(negedge clk);
                valid = 1'b0;
            end
            @(negedge clk);
            valid = 1'b1;
            wD    = w[i];
            last  = is_last && (i == 0);
        end
        @(negedge clk);
        valid = 1'b0;
        last  = 1'b0;
    endtask

    task automatic do_write(input txn_t t);
        data_t w;
        send_frame(t);
        @(negedge clk);
        check_ready(!t.accept);
        for (int i = 0; i < t.len; i++) begin
            w = lcg_next();
            send_word(w, (t.len > 1) && (i == t.len - 1));
            if (t.accept) begin
                ref_mem[t.addr + addr_t'(i)] = w;
            end
        end
        // word strobe cycle before the transfer ends
        check_ready(!t.accept);
        @(negedge clk);
        check_ready(1'b1);
    endtask

    task automatic do_read(input txn_t t);
        data_t w;
        int    cycles;
        send_frame(t);
        if (!t.accept) begin
            expect_idle(READ_DELAY + 2 * DATA_WIDTH);
        end else begin
            // cycles counted from the frame strobe cycle
            @(negedge clk);
            cycles = 1;
            check_ready(1'b0);
            for (int i = 0; i < t.len; i++) begin
                while (!rvalid) begin
                    @(negedge clk);
                    cycles++;
                end
                if (i == 0) begin
                    check_cycles("first word delay", cycles, READ_DELAY + 3);
                end else begin
                    check_cycles("gap between words", cycles, 2);
                end
                w = '0;
                for (int b = 0; b < DATA_WIDTH; b++) begin
                    if (!rvalid) begin
                        other_errors++;
                        $display("rvalid dropped in the middle of a read word");
                    end
                    w = {w[DATA_WIDTH-2:0], rD};
                    if (b == DATA_WIDTH - 1) begin
                        last = (i == t.len - 1);
                    end
                    @(negedge clk);
                end
                last = 1'b0;
                check_word(t.addr + addr_t'(i), w, ref_mem[t.addr + addr_t'(i)]);
                cycles = 0;
            end
            // done strobe cycle before the slave goes idle
            check_ready(1'b0);
            @(negedge clk);
            check_ready(1'b1);
        end
    endtask

    initial begin
        rstN    = 1'b0;
        control = 1'b0;
        wD      = 1'b0;
        valid   = 1'b0;
        last    = 1'b0;
        fill_table();
        cycle_limit = 3 * DATA_WIDTH + 20;
        foreach (txns[i]) begin
            cycle_limit += txn_cycles(txns[i]);
        end
        cycle_limit *= 2;

        repeat (5) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        // quiet bus first
        expect_idle(3 * DATA_WIDTH);

        foreach (txns[i]) begin
            if (txns[i].write) begin
                do_write(txns[i]);
            end else begin
                do_read(txns[i]);
            end
            @(negedge clk);
        end

        $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* serial_slave_assertions.sv */
// Protocol assertions on rvalid and ready, bound into every serial_slave instance
`timescale 1ns/1ps

module serial_slave_assertions (
    input logic clk,
    input logic rstN,
    input logic rvalid,
    input logic ready
);
    import serial_slave_pkg::*;

    int run_q;

    // length of the current rvalid run
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            run_q <= 0;
        end else begin
            run_q <= rvalid ? run_q + 1 : 0;
        end
    end

    no_overlap: assert property (@(posedge clk) disable iff (!rstN) !(rvalid && ready))
        else $error("rvalid and ready high in the same cycle");

    run_not_too_long: assert property (@(posedge clk) disable iff (!rstN)
        rvalid |-> (run_q < DATA_WIDTH))
        else $error("rvalid held longer than one word");

    run_not_too_short: assert property (@(posedge clk) disable iff (!rstN)
        (!rvalid && (run_q != 0)) |-> (run_q == DATA_WIDTH))
        else $error("rvalid run of %0d cycles", run_q);

    // first clock after reset release
    idle_after_reset: assert property (@(posedge clk) $rose(rstN) |-> (ready && !rvalid))
        else $error("slave not idle after reset");

endmodule

bind serial_slave serial_slave_assertions serial_slave_assertions_i (
    .clk    (clk),
    .rstN   (rstN),
    .rvalid (rvalid),
    .ready  (ready)
);

/* serial_slave.sv */
// Top level of the serial-bus memory slave; instantiate with this slave's id, read delay and depth
`timescale 1ns/1ps

module serial_slave #(
    parameter serial_slave_pkg::slave_id_t SLAVE_ID   = 2'd1,
    parameter int                          READ_DELAY = 2,
    parameter int                          MEM_DEPTH  = 256
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic rvalid,
    output logic ready
);
    import serial_slave_pkg::*;

    frame_t   frame;
    logic     frame_stb;
    wr_word_t word;
    logic     word_stb;
    logic     mem_we;
    logic     mem_re;
    addr_t    mem_addr;
    data_t    mem_wdata;
    data_t    mem_rdata;
    logic     load_stb;
    data_t    load_data;
    rd_done_t done;
    logic     done_stb;

    control_frame_receiver control_frame_receiver_i (
        .clk       (clk),
        .rstN      (rstN),
        .control   (control),
        .frame     (frame),
        .frame_stb (frame_stb)
    );

    // runs alongside the frame receiver
    write_word_receiver write_word_receiver_i (
        .clk      (clk),
        .rstN     (rstN),
        .wD       (wD),
        .valid    (valid),
        .last     (last),
        .word     (word),
        .word_stb (word_stb)
    );

    transfer_controller #(
        .SLAVE_ID   (SLAVE_ID),
        .READ_DELAY (READ_DELAY)
    ) transfer_controller_i (
        .clk       (clk),
        .rstN      (rstN),
        .frame     (frame),
        .frame_stb (frame_stb),
        .word      (word),
        .word_stb  (word_stb),
        .mem_rdata (mem_rdata),
        .done      (done),
        .done_stb  (done_stb),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .load_stb  (load_stb),
        .load_data (load_data),
        .ready     (ready)
    );

    word_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) word_memory_i (
        .clk   (clk),
        .we    (mem_we),
        .re    (mem_re),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    read_word_sender read_word_sender_i (
        .clk       (clk),
        .rstN      (rstN),
        .load_stb  (load_stb),
        .load_data (load_data),
        .last      (last),
        .rD        (rD),
        .rvalid    (rvalid),
        .done      (done),
        .done_stb  (done_stb)
    );

endmodule

/* read_word_sender.sv */
// Serializes a loaded memory word onto rD with rvalid and reports completion; used by serial_slave
`timescale 1ns/1ps

module read_word_sender (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        load_stb,
    input  serial_slave_pkg::data_t     load_data,
    input  logic                        last,
    output logic                        rD,
    output logic                        rvalid,
    output serial_slave_pkg::rd_done_t  done,
    output logic                        done_stb
);
    import serial_slave_pkg::*;

    localparam int CNT_W = $clog2(DATA_WIDTH);

    data_t            shift_q;
    logic [CNT_W-1:0] cnt_q;
    logic             rvalid_q;
    logic             done_stb_q;
    rd_done_t         done_q;
    logic             final_bit;

    assign final_bit = rvalid_q && (cnt_q == CNT_W'(DATA_WIDTH - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shift_q    <= '0;
            cnt_q      <= '0;
            rvalid_q   <= 1'b0;
            done_stb_q <= 1'b0;
        end else begin
            done_stb_q <= final_bit;
            if (load_stb) begin
                // MSB appears on rD next cycle
                shift_q  <= load_data;
                cnt_q    <= '0;
                rvalid_q <= 1'b1;
            end else if (rvalid_q) begin
                // zeros fill in behind so rD rests low
                shift_q <= shift_q << 1;
                cnt_q   <= cnt_q + 1'b1;
                if (final_bit) begin
                    rvalid_q <= 1'b0;
                end
            end
        end
    end

    // master flags the end of a burst on the final bit
    always_ff @(posedge clk) begin
        if (final_bit) begin
            done_q.last <= last;
        end
    end

    assign rD       = shift_q[DATA_WIDTH-1];
    assign rvalid   = rvalid_q;
    assign done     = done_q;
    assign done_stb = done_stb_q;

endmodule

/* word_memory.sv */
// Word-wide single-port storage with registered read for the serial slave
`timescale 1ns/1ps

module word_memory #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic                     re,
    input  serial_slave_pkg::addr_t  addr,
    input  serial_slave_pkg::data_t  wdata,
    output serial_slave_pkg::data_t  rdata
);
    import serial_slave_pkg::*;

    data_t mem [MEM_DEPTH];
    data_t rdata_q;
    logic  in_range;

    // addresses past the depth are not backed by storage
    assign in_range = int'(addr) < MEM_DEPTH;

    always_ff @(posedge clk) begin
        if (we && in_range) begin
            mem[addr] <= wdata;
        end
        if (re) begin
            rdata_q <= in_range ? mem[addr] : '0;
        end
    end

    assign rdata = rdata_q;

endmodule

/* transfer_controller.sv */
// Transfer FSM of the serial slave that checks frames, stores write words and times reads
`timescale 1ns/1ps

module transfer_controller #(
    parameter serial_slave_pkg::slave_id_t SLAVE_ID   = 2'd1,
    parameter int                          READ_DELAY = 2
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  serial_slave_pkg::frame_t    frame,
    input  logic                        frame_stb,
    input  serial_slave_pkg::wr_word_t  word,
    input  logic                        word_stb,
    input  serial_slave_pkg::data_t     mem_rdata,
    input  serial_slave_pkg::rd_done_t  done,
    input  logic                        done_stb,
    output logic                        mem_we,
    output logic                        mem_re,
    output serial_slave_pkg::addr_t     mem_addr,
    output serial_slave_pkg::data_t     mem_wdata,
    output logic                        load_stb,
    output serial_slave_pkg::data_t     load_data,
    output logic                        ready
);
    import serial_slave_pkg::*;

    localparam int DELAY_W = (READ_DELAY > 0) ? $clog2(READ_DELAY + 1) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_WAIT,
        ST_RD_FETCH,
        ST_RD_SEND,
        ST_WRITE
    } state_t;

    state_t             state_q;
    addr_t              addr_q;
    logic               burst_q;
    logic [DELAY_W-1:0] delay_q;
    logic               wr_pend_q;
    data_t              wr_data_q;
    logic               load_q;
    logic               frame_ok;
    logic               next_word;

    // only frames with the right start pattern and our id are taken
    assign frame_ok = frame_stb && (frame.start == START_PATTERN) && (frame.id == SLAVE_ID);

    // a continuing burst fetches at once so only two idle cycles separate words
    assign next_word = (state_q == ST_RD_SEND) && done_stb && burst_q && !done.last;

    assign mem_re    = (state_q == ST_RD_FETCH) || next_word;
    assign mem_we    = wr_pend_q;
    assign mem_wdata = wr_data_q;
    assign mem_addr  = addr_q;
    assign load_stb  = load_q;
    assign load_data = mem_rdata;
    assign ready     = (state_q == ST_IDLE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state_q   <= ST_IDLE;
            addr_q    <= '0;
            burst_q   <= 1'b0;
            delay_q   <= '0;
            wr_pend_q <= 1'b0;
            load_q    <= 1'b0;
        end else begin
            // read data comes back one cycle after mem_re
            load_q    <= mem_re;
            wr_pend_q <= 1'b0;
            // address steps after each memory write
            if (wr_pend_q) begin
                addr_q <= addr_q + 1'b1;
            end

            case (state_q)
                ST_IDLE: begin
                    if (frame_ok) begin
                        addr_q  <= frame.addr;
                        burst_q <= frame.burst;
                        delay_q <= DELAY_W'(READ_DELAY);
                        if (frame.write) begin
                            state_q <= ST_WRITE;
                        end else if (READ_DELAY == 0) begin
                            state_q <= ST_RD_FETCH;
                        end else begin
                            state_q <= ST_RD_WAIT;
                        end
                    end
                end
                ST_RD_WAIT: begin
                    delay_q <= delay_q - 1'b1;
                    if (delay_q == DELAY_W'(1)) begin
                        state_q <= ST_RD_FETCH;
                    end
                end
                ST_RD_FETCH: begin
                    // point at the next word ahead of time
                    addr_q  <= addr_q + 1'b1;
                    state_q <= ST_RD_SEND;
                end
                ST_RD_SEND: begin
                    if (done_stb) begin
                        if (next_word) begin
                            addr_q <= addr_q + 1'b1;
                        end else begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                ST_WRITE: begin
                    if (word_stb) begin
                        wr_pend_q <= 1'b1;
                        if (!burst_q || word.last) begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // words outside a write transfer are dropped
    always_ff @(posedge clk) begin
        if ((state_q == ST_WRITE) && word_stb) begin
            wr_data_q <= word.data;
        end
    end

endmodule

/* write_word_receiver.sv */
// Collects valid-qualified serial write bits into words with their last flag; used by serial_slave
`timescale 1ns/1ps

module write_word_receiver (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        wD,
    input  logic                        valid,
    input  logic                        last,
    output serial_slave_pkg::wr_word_t  word,
    output logic                        word_stb
);
    import serial_slave_pkg::*;

    localparam int CNT_W = $clog2(DATA_WIDTH);

    logic [CNT_W-1:0] cnt_q;
    data_t            shift_q;
    wr_word_t         word_q;
    logic             stb_q;
    logic             final_bit;

    assign final_bit = valid && (cnt_q == CNT_W'(DATA_WIDTH - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt_q <= '0;
            stb_q <= 1'b0;
        end else begin
            // counter only moves on qualified bits
            if (valid) begin
                cnt_q <= final_bit ? '0 : cnt_q + 1'b1;
            end
            stb_q <= final_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            shift_q <= {shift_q[DATA_WIDTH-2:0], wD};
        end
        // last is taken from the word's final bit only
        if (final_bit) begin
            word_q.data <= {shift_q[DATA_WIDTH-2:0], wD};
            word_q.last <= last;
        end
    end

    assign word     = word_q;
    assign word_stb = stb_q;

endmodule

/* control_frame_receiver.sv */
// Deserializes the control line into a frame struct with a one-cycle strobe; used by serial_slave
`timescale 1ns/1ps

module control_frame_receiver (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      control,
    output serial_slave_pkg::frame_t  frame,
    output logic                      frame_stb
);
    import serial_slave_pkg::*;

    localparam int CNT_W = $clog2(FRAME_BITS);

    logic                  busy_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [FRAME_BITS-1:0] shift_q;
    frame_t                frame_q;
    logic                  stb_q;
    logic                  last_bit;

    // final frame bit is on control this cycle
    assign last_bit = busy_q && (cnt_q == CNT_W'(FRAME_BITS - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            stb_q  <= 1'b0;
        end else begin
            stb_q <= 1'b0;
            if (!busy_q) begin
                // a high bit while idle is the first start bit
                if (control) begin
                    busy_q <= 1'b1;
                    cnt_q  <= CNT_W'(1);
                end
            end else begin
                cnt_q <= cnt_q + 1'b1;
                if (last_bit) begin
                    busy_q <= 1'b0;
                    stb_q  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy_q || control) begin
            shift_q <= {shift_q[FRAME_BITS-2:0], control};
        end
        // held until the next complete frame
        if (last_bit) begin
            frame_q <= frame_t'({shift_q[FRAME_BITS-2:0], control});
        end
    end

    assign frame     = frame_q;
    assign frame_stb = stb_q;

endmodule

/* serial_slave_pkg.sv */
// Shared widths, frame layout and bus structs for the serial memory slave; import where needed
package serial_slave_pkg;

    // word and address sizes
    localparam int DATA_WIDTH  = 32;
    localparam int ADDR_WIDTH  = 8;
    localparam int ID_WIDTH    = 2;

    // frame opens with three ones
    localparam int START_WIDTH = 3;
    localparam logic [START_WIDTH-1:0] START_PATTERN = 3'b111;

    // start + id + read/write + burst + address
    localparam int FRAME_BITS = START_WIDTH + ID_WIDTH + 1 + 1 + ADDR_WIDTH;

    typedef logic [DATA_WIDTH-1:0]  data_t;
    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [ID_WIDTH-1:0]    slave_id_t;
    typedef logic [START_WIDTH-1:0] start_t;

    // control frame sent MSB first in this bit order
    typedef struct packed {
        start_t    start;
        slave_id_t id;
        logic      write;
        logic      burst;
        addr_t     addr;
    } frame_t;

    // one received write word
    typedef struct packed {
        data_t data;
        logic  last;
    } wr_word_t;

    // completion info from the read sender
    typedef struct packed {
        logic last;
    } rd_done_t;

endpackage
